// File: src/add_compare_unit.sv
// Combinational; compare is only a subtraction when the decoder also sets complement and carry-in

`timescale 1ns/1ps

`include "alu_settings.svh"

module add_compare_unit (
    input  alu_pkg::word_t     op1,
    input  alu_pkg::word_t     op2,
    input  alu_pkg::alu_ctrl_t ctrl,
    output alu_pkg::word_t     sum,
    output logic               add_cout,
    output alu_pkg::alu_flags_t flags
);

    import alu_pkg::*;

    logic [`ALU_WIDTH:0] total;                // Sum with carry on top
    logic                sum_zero;
    alu_flags_t          flags_raw;

    assign total    = {1'b0, op1} + {1'b0, op2} + {{`ALU_WIDTH{1'b0}}, ctrl.carry_in};
    assign sum      = total[`ALU_WIDTH-1:0];
    assign add_cout = total[`ALU_WIDTH];
    assign sum_zero = (sum == word_t'(0));

    // Carry out of op1 + ~op2 + 1 means op1 >= op2
    assign flags_raw.gt = add_cout && !sum_zero;
    assign flags_raw.lt = !add_cout && !sum_zero;
    assign flags_raw.eq = sum_zero;

    always_comb
    begin
        if (ctrl.compare_true)
        begin
            flags = flags_raw;
        end
        else
        begin
            flags = '0;                        // Flags quiet outside compare
        end
    end

endmodule

// File: src/alu_pkg.sv
// Types only; jump, multiply and bitwise-NOT decode bits are not carried in the control word

`include "alu_settings.svh"

package alu_pkg;

    typedef logic [`ALU_WIDTH-1:0] word_t;   // Operand and result word

    // Decoded control word from the decode stage
    typedef struct packed {
        logic add_op;                         // Select adder result
        logic or_op;                          // Logical OR
        logic not_op;                         // Logical NOT of op1
        logic and_bitwise;
        logic or_bitwise;
        logic and_op;                         // Logical AND
        logic carry_in;                       // Adder carry input
        logic en_complement;                  // Invert op2
        logic compare_true;                   // Enable compare flags
        logic shift_left;
        logic lgcl_en;                        // Select logic result
        logic store_true;                     // Force op2 to zero
    } alu_ctrl_t;

    typedef struct packed {
        logic gt;
        logic lt;
        logic eq;
    } alu_flags_t;

    // Registered stage output, ALU_WIDTH + 4 bits
    typedef struct packed {
        word_t      dout;
        logic       cout;
        alu_flags_t flags;
    } alu_out_t;

endpackage

// File: src/alu_settings.svh
// Data width must stay at least 2 bits; the directed testbench table assumes 8

`ifndef ALU_SETTINGS_SVH
`define ALU_SETTINGS_SVH

// Operand and result word width
`define ALU_WIDTH 8

// Top bit index that a left shift moves into the carry
`define ALU_MSB (`ALU_WIDTH - 1)

`endif

// File: src/ex_alu.sv
// One cycle latency from inputs to alu_out; no handshake, a new operation may enter every edge

`timescale 1ns/1ps

module ex_alu (
    input  logic               shift_en,
    input  logic               rst_n,
    input  logic               alu_en,
    input  alu_pkg::word_t     op1_in,
    input  alu_pkg::word_t     op2_in,
    input  alu_pkg::alu_ctrl_t ctrl,
    output alu_pkg::alu_out_t  alu_out
);

    import alu_pkg::*;

    word_t      op1;
    word_t      op2;
    word_t      sum;
    logic       add_cout;
    alu_flags_t flags;
    word_t      lgcl_result;
    word_t      shift_result;
    logic       shift_cout;

    operand_cond i_operand_cond (
        .op1_in (op1_in),
        .op2_in (op2_in),
        .ctrl   (ctrl),
        .op1    (op1),
        .op2    (op2)
    );

    add_compare_unit i_add_compare_unit (
        .op1      (op1),
        .op2      (op2),
        .ctrl     (ctrl),
        .sum      (sum),
        .add_cout (add_cout),
        .flags    (flags)
    );

    logic_shift_unit i_logic_shift_unit (
        .op1          (op1),
        .op2          (op2),
        .ctrl         (ctrl),
        .lgcl_result  (lgcl_result),
        .shift_result (shift_result),
        .shift_cout   (shift_cout)
    );

    result_stage i_result_stage (
        .shift_en     (shift_en),
        .rst_n        (rst_n),
        .alu_en       (alu_en),
        .ctrl         (ctrl),
        .sum          (sum),
        .add_cout     (add_cout),
        .flags        (flags),
        .lgcl_result  (lgcl_result),
        .shift_result (shift_result),
        .shift_cout   (shift_cout),
        .alu_out      (alu_out)
    );

endmodule

// File: src/logic_shift_unit.sv
// Combinational; logical ops return 0 or 1 in bit 0 and the first set control bit wins

`timescale 1ns/1ps

`include "alu_settings.svh"

module logic_shift_unit (
    input  alu_pkg::word_t     op1,
    input  alu_pkg::word_t     op2,
    input  alu_pkg::alu_ctrl_t ctrl,
    output alu_pkg::word_t     lgcl_result,
    output alu_pkg::word_t     shift_result,
    output logic               shift_cout
);

    import alu_pkg::*;

    logic op1_nz;
    logic op2_nz;
    word_t lgcl_next;

    assign op1_nz = (op1 != word_t'(0));
    assign op2_nz = (op2 != word_t'(0));

    // Priority chain as decoded upstream
    always_comb
    begin
        if (ctrl.and_op)
        begin
            lgcl_next = word_t'(op1_nz && op2_nz);   // Logical AND
        end
        else if (ctrl.and_bitwise)
        begin
            lgcl_next = op1 & op2;
        end
        else if (ctrl.or_op)
        begin
            lgcl_next = word_t'(op1_nz || op2_nz);   // Logical OR
        end
        else if (ctrl.or_bitwise)
        begin
            lgcl_next = op1 | op2;
        end
        else if (ctrl.not_op)
        begin
            lgcl_next = word_t'(!op1_nz);            // Logical NOT of op1 only
        end
        else
        begin
            lgcl_next = word_t'(0);
        end
    end

    assign lgcl_result = lgcl_next;

    // Left shift by one with zero fill
    assign shift_result = {op1[`ALU_MSB-1:0], 1'b0};
    assign shift_cout   = op1[`ALU_MSB];            // Outgoing top bit

endmodule

// File: src/operand_cond.sv
// Combinational; a store forces op2 to zero ahead of any complement request

`timescale 1ns/1ps

module operand_cond (
    input  alu_pkg::word_t    op1_in,
    input  alu_pkg::word_t    op2_in,
    input  alu_pkg::alu_ctrl_t ctrl,
    output alu_pkg::word_t    op1,
    output alu_pkg::word_t    op2
);

    import alu_pkg::*;

    word_t op2_cond;

    // First operand is never modified
    assign op1 = op1_in;

    always_comb
    begin
        if (ctrl.store_true)
        begin
            op2_cond = word_t'(0);             // Store passes op1 through the adder
        end
        else if (ctrl.en_complement)
        begin
            op2_cond = ~op2_in;                // Ones complement for subtract
        end
        else
        begin
            op2_cond = op2_in;
        end
    end

    assign op2 = op2_cond;

endmodule

// File: src/result_stage.sv
// Output register loads only while alu_en is high so the other ALU can own the result path

`timescale 1ns/1ps

module result_stage (
    input  logic                shift_en,
    input  logic                rst_n,
    input  logic                alu_en,
    input  alu_pkg::alu_ctrl_t  ctrl,
    input  alu_pkg::word_t      sum,
    input  logic                add_cout,
    input  alu_pkg::alu_flags_t flags,
    input  alu_pkg::word_t      lgcl_result,
    input  alu_pkg::word_t      shift_result,
    input  logic                shift_cout,
    output alu_pkg::alu_out_t   alu_out
);

    import alu_pkg::*;

    alu_out_t out_next;
    alu_out_t out_q;

    // Result mux, adder first, then logic, shift as default
    always_comb
    begin
        if (ctrl.add_op)
        begin
            out_next.dout = sum;
        end
        else if (ctrl.lgcl_en)
        begin
            out_next.dout = lgcl_result;
        end
        else
        begin
            out_next.dout = shift_result;
        end
    end

    // Carry follows the adder only for adds
    always_comb
    begin
        if (ctrl.add_op)
        begin
            out_next.cout = add_cout;
        end
        else
        begin
            out_next.cout = shift_cout;           // Also taken for logic ops
        end
    end

    assign out_next.flags = flags;               // Always from the adder

    always_ff @(posedge shift_en or negedge rst_n)
    begin
        if (!rst_n)
        begin
            out_q <= '0;
        end
        else if (alu_en)
        begin
            out_q <= out_next;                   // Hold when disabled
        end
    end

    assign alu_out = out_q;

endmodule

// File: tb.f
+incdir+src
src/alu_pkg.sv
src/operand_cond.sv
src/add_compare_unit.sv
src/logic_shift_unit.sv
src/result_stage.sv
src/ex_alu.sv
verif/ex_alu_chk.sv
verif/ex_alu_tb.sv

// File: verif/ex_alu_chk.sv
// Checks hold from the first edge after reset; the hold and flag rules assume one-cycle latency

`timescale 1ns/1ps

module ex_alu_chk (
    input logic                shift_en,
    input logic                rst_n,
    input logic                alu_en,
    input alu_pkg::alu_ctrl_t  ctrl,
    input alu_pkg::alu_out_t   alu_out
);

    import alu_pkg::*;

    int fail_count = 0;                          // Failed assertions so far

    // Register is cleared by the edge after reset is seen low
    reset_clears: assert property (@(posedge shift_en)
        !rst_n |=> alu_out == alu_out_t'(0))
    else
    begin
        fail_count++;
        $error("alu_out not cleared during reset");
    end

    hold_when_disabled: assert property (@(posedge shift_en) disable iff (!rst_n)
        !alu_en |=> $stable(alu_out))
    else
    begin
        fail_count++;
        $error("alu_out changed with alu_en low");
    end

    flags_exclusive: assert property (@(posedge shift_en) disable iff (!rst_n)
        $onehot0(alu_out.flags))
    else
    begin
        fail_count++;
        $error("more than one compare flag set");
    end

    // Held outputs keep their flags
    flags_need_compare: assert property (@(posedge shift_en) disable iff (!rst_n)
        (alu_en && !ctrl.compare_true) |=> alu_out.flags == alu_flags_t'(0))
    else
    begin
        fail_count++;
        $error("compare flag set without compare_true");
    end

endmodule

// File: verif/ex_alu_tb.sv
// Directed table values assume an 8-bit word; the random phase follows ALU_WIDTH

`timescale 1ns/1ps

`include "alu_settings.svh"

module ex_alu_tb;

    import alu_pkg::*;

    typedef struct {
        string     name;
        logic      en;
        alu_ctrl_t ctrl;
        word_t     op1;
        word_t     op2;
        alu_out_t  exp;
    } row_t;

    localparam alu_ctrl_t ctrl_add   = '{add_op: 1'b1, default: 1'b0};
    localparam alu_ctrl_t ctrl_addc  = '{add_op: 1'b1, carry_in: 1'b1, default: 1'b0};
    localparam alu_ctrl_t ctrl_store = '{add_op: 1'b1, store_true: 1'b1, default: 1'b0};
    localparam alu_ctrl_t ctrl_cmp   = '{add_op: 1'b1, en_complement: 1'b1, carry_in: 1'b1,
                                         compare_true: 1'b1, default: 1'b0};
    localparam alu_ctrl_t ctrl_land  = '{lgcl_en: 1'b1, and_op: 1'b1, default: 1'b0};
    localparam alu_ctrl_t ctrl_band  = '{lgcl_en: 1'b1, and_bitwise: 1'b1, default: 1'b0};
    localparam alu_ctrl_t ctrl_lor   = '{lgcl_en: 1'b1, or_op: 1'b1, default: 1'b0};
    localparam alu_ctrl_t ctrl_bor   = '{lgcl_en: 1'b1, or_bitwise: 1'b1, default: 1'b0};
    localparam alu_ctrl_t ctrl_lnot  = '{lgcl_en: 1'b1, not_op: 1'b1, default: 1'b0};
    localparam alu_ctrl_t ctrl_lpri  = '{lgcl_en: 1'b1, and_op: 1'b1, or_bitwise: 1'b1,
                                         default: 1'b0};
    localparam alu_ctrl_t ctrl_lnone = '{lgcl_en: 1'b1, default: 1'b0};
    localparam alu_ctrl_t ctrl_shl   = '{shift_left: 1'b1, default: 1'b0};

    logic      shift_en;
    logic      rst_n;
    logic      alu_en;
    word_t     op1_in;
    word_t     op2_in;
    alu_ctrl_t ctrl;
    alu_out_t  alu_out;
    row_t      rows[$];
    integer    seed;
    int        errors;
    int        checks;
    alu_out_t  prev_exp;

    ex_alu i_ex_alu (
        .shift_en (shift_en),
        .rst_n    (rst_n),
        .alu_en   (alu_en),
        .op1_in   (op1_in),
        .op2_in   (op2_in),
        .ctrl     (ctrl),
        .alu_out  (alu_out)
    );

    bind ex_alu ex_alu_chk i_ex_alu_chk (
        .shift_en (shift_en),
        .rst_n    (rst_n),
        .alu_en   (alu_en),
        .ctrl     (ctrl),
        .alu_out  (alu_out)
    );

    always #10 shift_en = ~shift_en;                 // 20 ns period

    // Expected result straight from the operand, adder, logic and select rules
    function automatic alu_out_t model_alu(input alu_ctrl_t c, input word_t a, input word_t b_in);
        word_t               b;
        word_t               lg;
        logic [`ALU_WIDTH:0] total;
        logic                zero;
        alu_out_t            r;
        b = c.store_true ? '0 : (c.en_complement ? ~b_in : b_in);
        total = {1'b0, a} + {1'b0, b} + {{`ALU_WIDTH{1'b0}}, c.carry_in};
        zero = (total[`ALU_WIDTH-1:0] == '0);
        r.flags.gt = c.compare_true && total[`ALU_WIDTH] && !zero;
        r.flags.lt = c.compare_true && !total[`ALU_WIDTH] && !zero;
        r.flags.eq = c.compare_true && zero;
        if (c.and_op)
            lg = {{`ALU_MSB{1'b0}}, (a != '0) && (b != '0)};
        else if (c.and_bitwise)
            lg = a & b;
        else if (c.or_op)
            lg = {{`ALU_MSB{1'b0}}, (a != '0) || (b != '0)};
        else if (c.or_bitwise)
            lg = a | b;
        else
            lg = {{`ALU_MSB{1'b0}}, c.not_op && (a == '0)};
        r.dout = c.add_op ? total[`ALU_WIDTH-1:0] : (c.lgcl_en ? lg : {a[`ALU_MSB-1:0], 1'b0});
        r.cout = c.add_op ? total[`ALU_WIDTH] : a[`ALU_MSB];
        return r;
    endfunction

    task automatic add_row(input string name, input logic en, input alu_ctrl_t c, input word_t a,
                           input word_t b, input word_t d, input logic co, input logic [2:0] f);
        row_t r;
        r.name = name;
        r.en = en;
        r.ctrl = c;
        r.op1 = a;
        r.op2 = b;
        r.exp.dout = d;
        r.exp.cout = co;
        r.exp.flags = f;                             // gt, lt, eq
        rows.push_back(r);
    endtask

    task automatic compare_out(input string name, input alu_out_t exp);
        checks++;
        if (alu_out !== exp)
        begin
            errors++;
            $display("mismatch %s: expected dout=%h cout=%b flags=%b actual dout=%h cout=%b flags=%b",
                     name, exp.dout, exp.cout, exp.flags, alu_out.dout, alu_out.cout, alu_out.flags);
        end
    endtask

    // Drive on one edge, captured on the next, read at the falling edge after it
    task automatic apply_op(input string name, input logic en, input alu_ctrl_t c, input word_t a,
                            input word_t b, input alu_out_t exp);
        @(posedge shift_en);
        alu_en <= en;
        ctrl <= c;
        op1_in <= a;
        op2_in <= b;
        @(posedge shift_en);
        @(negedge shift_en);
        compare_out(name, exp);
    endtask

    task automatic run_tests();
        logic [31:0] rnd;
        alu_ctrl_t   r_ctrl;
        logic        r_en;
        word_t       r_op1;
        word_t       r_op2;
        alu_out_t    r_exp;
        @(negedge shift_en);
        compare_out("after_reset", alu_out_t'(0));
        prev_exp = '0;
        foreach (rows[k])
        begin
            apply_op(rows[k].name, rows[k].en, rows[k].ctrl, rows[k].op1, rows[k].op2, rows[k].exp);
            prev_exp = rows[k].exp;
        end
        for (int i = 0; i < 200; i++)
        begin
            rnd = $random(seed);
            r_ctrl = rnd[11:0];
            r_en = (rnd[14:12] != 3'b000);           // Mostly enabled
            rnd = $random(seed);
            r_op1 = rnd[`ALU_WIDTH-1:0];
            r_op2 = rnd[`ALU_WIDTH+15:16];
            r_exp = r_en ? model_alu(r_ctrl, r_op1, r_op2) : prev_exp;
            apply_op($sformatf("random_%0d", i), r_en, r_ctrl, r_op1, r_op2, r_exp);
            prev_exp = r_exp;
        end
    endtask

    initial
    begin
        repeat (10) @(posedge shift_en);
        rst_n <= 1'b1;
    end

    initial
    begin
        int wait_cycles;
        shift_en = 1'b0;
        rst_n = 1'b0;
        alu_en = 1'b0;
        ctrl = '0;
        op1_in = '0;
        op2_in = '0;
        seed = 32'h3655;
        errors = 0;
        checks = 0;
        add_row("add_basic",     1'b1, ctrl_add,   8'h12, 8'h34, 8'h46, 1'b0, 3'b000);
        add_row("add_carry_in",  1'b1, ctrl_addc,  8'h12, 8'h34, 8'h47, 1'b0, 3'b000);
        add_row("add_overflow",  1'b1, ctrl_add,   8'hF0, 8'h20, 8'h10, 1'b1, 3'b000);
        add_row("store_op1",     1'b1, ctrl_store, 8'h5A, 8'hFF, 8'h5A, 1'b0, 3'b000);
        add_row("cmp_gt",        1'b1, ctrl_cmp,   8'h30, 8'h10, 8'h20, 1'b1, 3'b100);
        add_row("cmp_lt",        1'b1, ctrl_cmp,   8'h10, 8'h30, 8'hE0, 1'b0, 3'b010);
        add_row("cmp_eq",        1'b1, ctrl_cmp,   8'h42, 8'h42, 8'h00, 1'b1, 3'b001);
        add_row("add_no_flags",  1'b1, ctrl_add,   8'h80, 8'h80, 8'h00, 1'b1, 3'b000);
        add_row("land_true",     1'b1, ctrl_land,  8'h04, 8'h80, 8'h01, 1'b0, 3'b000);
        add_row("land_false",    1'b1, ctrl_land,  8'h04, 8'h00, 8'h00, 1'b0, 3'b000);
        add_row("band",          1'b1, ctrl_band,  8'hCC, 8'hAA, 8'h88, 1'b1, 3'b000);
        add_row("lor_true",      1'b1, ctrl_lor,   8'h00, 8'h10, 8'h01, 1'b0, 3'b000);
        add_row("lor_false",     1'b1, ctrl_lor,   8'h00, 8'h00, 8'h00, 1'b0, 3'b000);
        add_row("bor",           1'b1, ctrl_bor,   8'h0C, 8'hA0, 8'hAC, 1'b0, 3'b000);
        add_row("lnot_zero",     1'b1, ctrl_lnot,  8'h00, 8'h55, 8'h01, 1'b0, 3'b000);
        add_row("lnot_nonzero",  1'b1, ctrl_lnot,  8'h81, 8'h00, 8'h00, 1'b1, 3'b000);
        add_row("land_over_bor", 1'b1, ctrl_lpri,  8'h03, 8'h0C, 8'h01, 1'b0, 3'b000);
        add_row("logic_default", 1'b1, ctrl_lnone, 8'h77, 8'h11, 8'h00, 1'b0, 3'b000);
        add_row("shl_top_set",   1'b1, ctrl_shl,   8'hA5, 8'h00, 8'h4A, 1'b1, 3'b000);
        add_row("shl_top_clear", 1'b1, ctrl_shl,   8'h41, 8'h00, 8'h82, 1'b0, 3'b000);
        add_row("hold_add",      1'b0, ctrl_add,   8'hFF, 8'hFF, 8'h82, 1'b0, 3'b000);
        add_row("hold_cmp",      1'b0, ctrl_cmp,   8'h01, 8'h02, 8'h82, 1'b0, 3'b000);
        add_row("resume_add",    1'b1, ctrl_add,   8'h01, 8'h01, 8'h02, 1'b0, 3'b000);
        wait_cycles = 0;
        while (!rst_n && wait_cycles < 50)
        begin
            @(posedge shift_en);
            wait_cycles++;
        end
        if (!rst_n)
        begin
            $display("Reset was never released after %0d cycles", wait_cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
        else
        begin
            run_tests();
            $display("Checks run: %0d, errors: %0d, assertion failures: %0d",
                     checks, errors, i_ex_alu.i_ex_alu_chk.fail_count);
            if (errors == 0 && i_ex_alu.i_ex_alu_chk.fail_count == 0)
                $display("Simulation finished: PASS");
            else
                $display("Simulation finished: FAIL");
            $finish;
        end
    end

endmodule
